// File: build.f
+incdir+src
src/vmul_pkg.sv
src/vmul_insn_queue.sv
src/vmul_issue.sv
src/vmul_simd_mul.sv
src/vmul_writeback.sv
src/vmul_unit.sv
verification/vmul_sva.sv
verification/vmul_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the vector multiply testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module vmul_tb -o vmul_sim
if [ $? -ne 0 ]; then
  echo "Compilation failed"
  exit 1
fi

./obj_dir/vmul_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi

// File: src/vmul_defines.svh
// Width, depth and latency macros of the vector multiply unit
`ifndef VMUL_DEFINES_SVH
`define VMUL_DEFINES_SVH

// Element word and its byte enable
`define VMUL_ELEN 64
`define VMUL_STRB 8

// Instruction ids and queue depths
`define VMUL_NR_VINSN 4
`define VMUL_INSN_DEPTH 4
`define VMUL_RESQ_DEPTH 2

// Multiplier pipeline stages
`define VMUL_LAT 2

// Vector length counts up to 64 elements
`define VMUL_VL_W 7

// Register file geometry
`define VMUL_VREG_WORDS 8
`define VMUL_ADDR_W 8

`endif

// File: src/vmul_insn_queue.sv
// Four-entry in-flight instruction queue with issue, processing and commit phases
`include "vmul_defines.svh"
`default_nettype none

module vmul_insn_queue import vmul_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  vinsn_t vinsn_i,
  input  logic   vinsn_valid_i,
  output logic   ready_o,
  output vinsn_t issue_insn_o,
  output logic   issue_valid_o,
  input  logic   issue_done_i,
  output vinsn_t proc_insn_o,
  input  logic   proc_done_i,
  output vinsn_t commit_insn_o,
  output logic   commit_valid_o,
  input  logic   commit_done_i
);

  localparam int unsigned Depth = `VMUL_INSN_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);
  localparam logic [CntW-1:0] Full = `VMUL_INSN_DEPTH;

  vinsn_t          mem_q [Depth];
  logic [PtrW-1:0] accept_pnt_q;
  logic [PtrW-1:0] issue_pnt_q;
  logic [PtrW-1:0] proc_pnt_q;
  logic [PtrW-1:0] commit_pnt_q;
  logic [CntW-1:0] issue_cnt_q;
  logic [CntW-1:0] commit_cnt_q;
  logic            accept;

  // A slot is free again only once its results are committed
  assign ready_o = (commit_cnt_q != Full);
  assign accept  = vinsn_valid_i & ready_o;

  assign issue_insn_o   = mem_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_insn_o    = mem_q[proc_pnt_q];
  assign commit_insn_o  = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= vinsn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (proc_done_i) begin
        proc_pnt_q <= proc_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      // Pointers wrap naturally, the depth is a power of two
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(commit_done_i);
    end
  end

endmodule

`default_nettype wire

// File: src/vmul_issue.sv
// Issue stage with operand handshake, scalar replication, element counting and byte enables
`include "vmul_defines.svh"
`default_nettype none

module vmul_issue import vmul_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  vinsn_t                     insn_i,
  input  logic                       insn_valid_i,
  input  logic [2:0][`VMUL_ELEN-1:0] operand_i,
  input  logic [2:0]                 operand_valid_i,
  output logic [2:0]                 operand_ready_o,
  input  logic [`VMUL_STRB-1:0]      mask_i,
  input  logic                       mask_valid_i,
  output logic                       mask_ready_o,
  output logic                       mul_valid_o,
  input  logic                       mul_ready_i,
  output logic [`VMUL_ELEN-1:0]      op_a_o,
  output logic [`VMUL_ELEN-1:0]      op_b_o,
  output logic [`VMUL_ELEN-1:0]      op_c_o,
  output logic [`VMUL_STRB-1:0]      mask_o,
  output logic                       issue_done_o
);

  localparam int unsigned VlW = `VMUL_VL_W;

  elem_word_u            scalar_rep;
  logic [VlW-1:0]        cnt_q;
  logic [VlW-1:0]        remaining;
  logic [3:0]            per_word;
  logic [3:0]            elem_n;
  logic [3:0]            n_bytes;
  logic [`VMUL_STRB-1:0] issue_be;
  logic                  operands_valid;
  logic                  fire;

  // Scalar copied into every lane of the word
  always_comb begin
    scalar_rep.d = '0;
    case (insn_i.vsew)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          scalar_rep.b[i] = insn_i.scalar_op[7:0];
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          scalar_rep.h[i] = insn_i.scalar_op[15:0];
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          scalar_rep.w[i] = insn_i.scalar_op[31:0];
        end
      end
      default: scalar_rep.d = insn_i.scalar_op;
    endcase
  end

  assign op_a_o = insn_i.use_scalar_op ? scalar_rep.d : operand_i[0];
  assign op_b_o = operand_i[1];
  assign op_c_o = operand_i[2];

  // Unused operands never hold back the micro-operation
  assign operands_valid = (operand_valid_i[0] | ~insn_i.use_vs1)
                        & (operand_valid_i[1] | ~insn_i.use_vs2)
                        & (operand_valid_i[2] | ~insn_i.use_vd)
                        & (mask_valid_i | insn_i.vm);

  assign mul_valid_o = insn_valid_i & operands_valid;
  assign fire        = mul_valid_o & mul_ready_i;

  assign operand_ready_o = fire ? {insn_i.use_vd, insn_i.use_vs2, insn_i.use_vs1} : 3'b000;
  assign mask_ready_o    = fire & ~insn_i.vm;

  // Zero count means the head instruction has not issued yet
  assign remaining = (cnt_q == '0) ? insn_i.vl : cnt_q;
  assign per_word  = 4'd8 >> insn_i.vsew;
  assign elem_n    = (VlW'(per_word) > remaining) ? remaining[3:0] : per_word;
  assign n_bytes   = elem_n << insn_i.vsew;

  // Tail bytes of a partial word are dropped from the carried mask
  assign issue_be = ~({`VMUL_STRB{1'b1}} << n_bytes);
  assign mask_o   = issue_be & (insn_i.vm ? {`VMUL_STRB{1'b1}} : mask_i);

  assign issue_done_o = fire & (remaining == VlW'(elem_n));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (fire) begin
      cnt_q <= remaining - VlW'(elem_n);
    end
  end

endmodule

`default_nettype wire

// File: src/vmul_pkg.sv
// Operation and element-width enums, queued instruction struct and element word union
`include "vmul_defines.svh"
`default_nettype none

package vmul_pkg;

  typedef enum logic [1:0] {
    VMUL,
    VMULHU,
    VMACC
  } vmul_op_e;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef struct packed {
    logic [1:0]            id;
    vmul_op_e              op;
    vew_e                  vsew;
    logic [`VMUL_VL_W-1:0] vl;
    logic [4:0]            vd;
    logic [`VMUL_ELEN-1:0] scalar_op;
    logic                  use_scalar_op;
    logic                  use_vs1;
    logic                  use_vs2;
    logic                  use_vd;
    logic                  vm;
  } vinsn_t;

  // One 64-bit word seen as lanes of each element width
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } elem_word_u;

endpackage

`default_nettype wire

// File: src/vmul_simd_mul.sv
// Pipelined SIMD integer multiplier for all element widths, carrying the mask
`include "vmul_defines.svh"
`default_nettype none

module vmul_simd_mul import vmul_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vmul_op_e              op_i,
  input  vew_e                  vsew_i,
  input  logic [`VMUL_ELEN-1:0] op_a_i,
  input  logic [`VMUL_ELEN-1:0] op_b_i,
  input  logic [`VMUL_ELEN-1:0] op_c_i,
  input  logic [`VMUL_STRB-1:0] mask_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output logic [`VMUL_ELEN-1:0] result_o,
  output logic [`VMUL_STRB-1:0] mask_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int unsigned Lat = `VMUL_LAT;

  elem_word_u                   a;
  elem_word_u                   b;
  elem_word_u                   c;
  elem_word_u                   r;
  logic [Lat:0]                 stg_rdy;
  logic [Lat-1:0]               stg_vld;
  logic [Lat-1:0][`VMUL_ELEN-1:0] stg_res;
  logic [Lat-1:0][`VMUL_STRB-1:0] stg_msk;
  logic [Lat-1:0]               vld_q;
  logic [Lat-1:0][`VMUL_ELEN-1:0] res_q;
  logic [Lat-1:0][`VMUL_STRB-1:0] msk_q;

  // One lane of w bits, zero-extended to 64
  function automatic logic [63:0] lane_op(input vmul_op_e op, input logic [63:0] x,
                                          input logic [63:0] y, input logic [63:0] acc,
                                          input int unsigned w);
    logic [127:0] prod;
    logic [63:0]  lmask;
    logic [63:0]  lo;
    logic [63:0]  hi;
    lmask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    prod  = {64'd0, x & lmask} * {64'd0, y & lmask};
    lo    = prod[63:0] & lmask;
    hi    = 64'(prod >> w) & lmask;
    case (op)
      VMULHU:  lane_op = hi;
      VMACC:   lane_op = (acc + lo) & lmask;
      default: lane_op = lo;
    endcase
  endfunction

  assign a.d = op_a_i;
  assign b.d = op_b_i;
  assign c.d = op_c_i;

  always_comb begin
    r.d = '0;
    case (vsew_i)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          r.b[i] = 8'(lane_op(op_i, 64'(a.b[i]), 64'(b.b[i]), 64'(c.b[i]), 8));
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          r.h[i] = 16'(lane_op(op_i, 64'(a.h[i]), 64'(b.h[i]), 64'(c.h[i]), 16));
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          r.w[i] = 32'(lane_op(op_i, 64'(a.w[i]), 64'(b.w[i]), 64'(c.w[i]), 32));
        end
      end
      default: r.d = lane_op(op_i, a.d, b.d, c.d, 64);
    endcase
  end

  // Stage inputs and a ready chain that lets bubbles collapse
  always_comb begin
    stg_vld[0]   = valid_i;
    stg_res[0]   = r.d;
    stg_msk[0]   = mask_i;
    for (int s = 1; s < Lat; s++) begin
      stg_vld[s] = vld_q[s-1];
      stg_res[s] = res_q[s-1];
      stg_msk[s] = msk_q[s-1];
    end
    stg_rdy[Lat] = ready_i;
    for (int s = Lat - 1; s >= 0; s--) begin
      stg_rdy[s] = ~vld_q[s] | stg_rdy[s+1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      for (int s = 0; s < Lat; s++) begin
        if (stg_rdy[s]) begin
          vld_q[s] <= stg_vld[s];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int s = 0; s < Lat; s++) begin
      if (stg_rdy[s] && stg_vld[s]) begin
        res_q[s] <= stg_res[s];
        msk_q[s] <= stg_msk[s];
      end
    end
  end

  assign ready_o  = stg_rdy[0];
  assign valid_o  = vld_q[Lat-1];
  assign result_o = res_q[Lat-1];
  assign mask_o   = msk_q[Lat-1];

endmodule

`default_nettype wire

// File: src/vmul_unit.sv
// Vector integer multiply unit top level connecting queue, issue, multiplier and writeback
`include "vmul_defines.svh"
`default_nettype none

module vmul_unit import vmul_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  vinsn_t                     vinsn_i,
  input  logic                       vinsn_valid_i,
  output logic                       ready_o,
  input  logic [2:0][`VMUL_ELEN-1:0] operand_i,
  input  logic [2:0]                 operand_valid_i,
  output logic [2:0]                 operand_ready_o,
  input  logic [`VMUL_STRB-1:0]      mask_i,
  input  logic                       mask_valid_i,
  output logic                       mask_ready_o,
  output logic                       result_req_o,
  output logic [1:0]                 result_id_o,
  output logic [`VMUL_ADDR_W-1:0]    result_addr_o,
  output logic [`VMUL_ELEN-1:0]      result_wdata_o,
  output logic [`VMUL_STRB-1:0]      result_be_o,
  input  logic                       result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0]  vinsn_done_o
);

  vinsn_t                issue_insn;
  vinsn_t                proc_insn;
  vinsn_t                commit_insn;
  logic                  issue_valid;
  logic                  issue_done;
  logic                  proc_done;
  logic                  commit_valid;
  logic                  commit_done;
  logic                  mul_in_valid;
  logic                  mul_in_ready;
  logic                  mul_out_valid;
  logic                  mul_out_ready;
  logic [`VMUL_ELEN-1:0] op_a;
  logic [`VMUL_ELEN-1:0] op_b;
  logic [`VMUL_ELEN-1:0] op_c;
  logic [`VMUL_ELEN-1:0] mul_res;
  logic [`VMUL_STRB-1:0] issue_mask;
  logic [`VMUL_STRB-1:0] mul_mask;

  vmul_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .vinsn_i       (vinsn_i),
    .vinsn_valid_i (vinsn_valid_i),
    .ready_o       (ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .proc_insn_o   (proc_insn),
    .proc_done_i   (proc_done),
    .commit_insn_o (commit_insn),
    .commit_valid_o(commit_valid),
    .commit_done_i (commit_done)
  );

  vmul_issue i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (issue_insn),
    .insn_valid_i   (issue_valid),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mask_i         (mask_i),
    .mask_valid_i   (mask_valid_i),
    .mask_ready_o   (mask_ready_o),
    .mul_valid_o    (mul_in_valid),
    .mul_ready_i    (mul_in_ready),
    .op_a_o         (op_a),
    .op_b_o         (op_b),
    .op_c_o         (op_c),
    .mask_o         (issue_mask),
    .issue_done_o   (issue_done)
  );

  // Operation and width follow the instruction at the issue phase
  vmul_simd_mul i_simd_mul (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .op_i    (issue_insn.op),
    .vsew_i  (issue_insn.vsew),
    .op_a_i  (op_a),
    .op_b_i  (op_b),
    .op_c_i  (op_c),
    .mask_i  (issue_mask),
    .valid_i (mul_in_valid),
    .ready_o (mul_in_ready),
    .result_o(mul_res),
    .mask_o  (mul_mask),
    .valid_o (mul_out_valid),
    .ready_i (mul_out_ready)
  );

  vmul_writeback i_writeback (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .proc_insn_i   (proc_insn),
    .proc_done_o   (proc_done),
    .commit_insn_i (commit_insn),
    .commit_valid_i(commit_valid),
    .commit_done_o (commit_done),
    .res_i         (mul_res),
    .res_mask_i    (mul_mask),
    .res_valid_i   (mul_out_valid),
    .res_ready_o   (mul_out_ready),
    .result_req_o  (result_req_o),
    .result_id_o   (result_id_o),
    .result_addr_o (result_addr_o),
    .result_wdata_o(result_wdata_o),
    .result_be_o   (result_be_o),
    .result_gnt_i  (result_gnt_i),
    .vinsn_done_o  (vinsn_done_o)
  );

endmodule

`default_nettype wire

// File: src/vmul_writeback.sv
// Writeback with processing count, address and byte enables, result queue and commit tracking
`include "vmul_defines.svh"
`default_nettype none

module vmul_writeback import vmul_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vinsn_t                    proc_insn_i,
  output logic                      proc_done_o,
  input  vinsn_t                    commit_insn_i,
  input  logic                      commit_valid_i,
  output logic                      commit_done_o,
  input  logic [`VMUL_ELEN-1:0]     res_i,
  input  logic [`VMUL_STRB-1:0]     res_mask_i,
  input  logic                      res_valid_i,
  output logic                      res_ready_o,
  output logic                      result_req_o,
  output logic [1:0]                result_id_o,
  output logic [`VMUL_ADDR_W-1:0]   result_addr_o,
  output logic [`VMUL_ELEN-1:0]     result_wdata_o,
  output logic [`VMUL_STRB-1:0]     result_be_o,
  input  logic                      result_gnt_i,
  output logic [`VMUL_NR_VINSN-1:0] vinsn_done_o
);

  localparam int unsigned Depth = `VMUL_RESQ_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);
  localparam int unsigned VlW   = `VMUL_VL_W;
  localparam int unsigned AddrW = `VMUL_ADDR_W;
  localparam logic [CntW-1:0]  Full      = `VMUL_RESQ_DEPTH;
  localparam logic [AddrW-1:0] VregWords = `VMUL_VREG_WORDS;

  logic [1:0]            q_id    [Depth];
  logic [AddrW-1:0]      q_addr  [Depth];
  logic [`VMUL_ELEN-1:0] q_wdata [Depth];
  logic [`VMUL_STRB-1:0] q_be    [Depth];
  logic [PtrW-1:0]       wr_pnt_q;
  logic [PtrW-1:0]       rd_pnt_q;
  logic [CntW-1:0]       q_cnt_q;

  logic [VlW-1:0]        proc_cnt_q;
  logic [VlW-1:0]        proc_rem;
  logic [VlW-1:0]        word_idx;
  logic [3:0]            proc_per_word;
  logic [3:0]            proc_n;
  logic [3:0]            proc_bytes;
  logic [AddrW-1:0]      wr_addr;
  logic [`VMUL_STRB-1:0] wr_be;
  logic                  push;

  logic [VlW-1:0]        commit_cnt_q;
  logic [VlW-1:0]        commit_rem;
  logic [3:0]            commit_per_word;
  logic [3:0]            commit_n;
  logic                  pop;

  // Processing side, one word per multiplier result
  assign proc_rem      = (proc_cnt_q == '0) ? proc_insn_i.vl : proc_cnt_q;
  assign proc_per_word = 4'd8 >> proc_insn_i.vsew;
  assign proc_n        = (VlW'(proc_per_word) > proc_rem) ? proc_rem[3:0] : proc_per_word;
  assign proc_bytes    = proc_n << proc_insn_i.vsew;

  // Word index is the count of elements already written divided by lanes per word
  assign word_idx = (proc_insn_i.vl - proc_rem) >> (2'd3 - proc_insn_i.vsew);
  assign wr_addr  = VregWords * AddrW'(proc_insn_i.vd) + AddrW'(word_idx);
  assign wr_be    = ~({`VMUL_STRB{1'b1}} << proc_bytes)
                  & (proc_insn_i.vm ? {`VMUL_STRB{1'b1}} : res_mask_i);

  assign res_ready_o = (q_cnt_q != Full);
  assign push        = res_valid_i & res_ready_o;
  assign proc_done_o = push & (proc_rem == VlW'(proc_n));

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_id[wr_pnt_q]    <= proc_insn_i.id;
      q_addr[wr_pnt_q]  <= wr_addr;
      q_wdata[wr_pnt_q] <= res_i;
      q_be[wr_pnt_q]    <= wr_be;
    end
  end

  // Register file port, held until granted
  assign result_req_o   = (q_cnt_q != '0);
  assign result_id_o    = q_id[rd_pnt_q];
  assign result_addr_o  = q_addr[rd_pnt_q];
  assign result_wdata_o = q_wdata[rd_pnt_q];
  assign result_be_o    = q_be[rd_pnt_q];

  // Commit side counts elements as their words are granted
  assign pop             = result_gnt_i & result_req_o;
  assign commit_rem      = (commit_cnt_q == '0) ? commit_insn_i.vl : commit_cnt_q;
  assign commit_per_word = 4'd8 >> commit_insn_i.vsew;
  assign commit_n        = (VlW'(commit_per_word) > commit_rem) ? commit_rem[3:0]
                                                                 : commit_per_word;
  assign commit_done_o   = pop & commit_valid_i & (commit_rem == VlW'(commit_n));

  assign vinsn_done_o = commit_done_o
                      ? ({{(`VMUL_NR_VINSN-1){1'b0}}, 1'b1} << commit_insn_i.id)
                      : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
      wr_pnt_q     <= '0;
      rd_pnt_q     <= '0;
      q_cnt_q      <= '0;
    end else begin
      if (push) begin
        proc_cnt_q <= proc_rem - VlW'(proc_n);
        wr_pnt_q   <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        commit_cnt_q <= commit_rem - VlW'(commit_n);
        rd_pnt_q     <= rd_pnt_q + 1'b1;
      end
      q_cnt_q <= q_cnt_q + CntW'(push) - CntW'(pop);
    end
  end

endmodule

`default_nettype wire

// File: verification/vmul_sva.sv
// Bound assertions on the register-file port, operand acknowledgements and done pulses
`include "vmul_defines.svh"
`default_nettype none

module vmul_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      req_i,
  input logic                      gnt_i,
  input logic [1:0]                id_i,
  input logic [`VMUL_ADDR_W-1:0]   addr_i,
  input logic [`VMUL_ELEN-1:0]     wdata_i,
  input logic [`VMUL_STRB-1:0]     be_i,
  input logic [2:0]                operand_ready_i,
  input logic                      mask_ready_i,
  input logic [`VMUL_NR_VINSN-1:0] done_i
);

  // A pending request keeps its payload until granted
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable(id_i) && $stable(addr_i)
                        && $stable(wdata_i) && $stable(be_i))
    else $error("result request dropped or changed before its grant");

  // Nothing is acknowledged or requested in reset and on the first edge after it
  quiet_reset_a: assert property (@(posedge clk_i)
    !rst_ni || $rose(rst_ni) |-> operand_ready_i == '0 && !mask_ready_i
                                 && !req_i && done_i == '0)
    else $error("control output active around reset");

  done_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(done_i))
    else $error("more than one done bit set");

endmodule

bind vmul_unit vmul_sva i_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_i          (result_req_o),
  .gnt_i          (result_gnt_i),
  .id_i           (result_id_o),
  .addr_i         (result_addr_o),
  .wdata_i        (result_wdata_o),
  .be_i           (result_be_o),
  .operand_ready_i(operand_ready_o),
  .mask_ready_i   (mask_ready_o),
  .done_i         (vinsn_done_o)
);

`default_nettype wire

// File: verification/vmul_tb.sv
// Testbench for the vector multiply unit with instruction table, drivers, reference model and watchdog
`include "vmul_defines.svh"
`default_nettype none

module vmul_tb import vmul_pkg::*; ();

  localparam int NROWS = 13;
  localparam logic [31:0] SEED = 32'h9974_1a0f;

  typedef struct packed {
    vmul_op_e    op;
    vew_e        vsew;
    logic [6:0]  vl;
    logic [4:0]  vd;
    logic        vm;
    logic        sc;
    logic [63:0] scalar;
    logic [31:0] seed;
  } row_t;

  logic                              clk_i = 1'b0;
  logic                              rst_ni;
  vinsn_t                            vinsn_i;
  logic                              vinsn_valid_i;
  logic                              ready_o;
  logic [2:0][`VMUL_ELEN-1:0]        operand_i;
  logic [2:0]                        operand_valid_i;
  logic [2:0]                        operand_ready_o;
  logic [`VMUL_STRB-1:0]             mask_i;
  logic                              mask_valid_i;
  logic                              mask_ready_o;
  logic                              result_req_o;
  logic [1:0]                        result_id_o;
  logic [`VMUL_ADDR_W-1:0]           result_addr_o;
  logic [`VMUL_ELEN-1:0]             result_wdata_o;
  logic [`VMUL_STRB-1:0]             result_be_o;
  logic                              result_gnt_i;
  logic [`VMUL_NR_VINSN-1:0]         vinsn_done_o;

  row_t        rows [NROWS];
  logic [63:0] vs1_q[$];
  logic [63:0] vs2_q[$];
  logic [63:0] vd_q[$];
  logic [7:0]  mask_q[$];
  int          row_of[$];
  logic [1:0]  exp_id[$];
  logic [7:0]  exp_addr[$];
  logic [7:0]  exp_be[$];
  logic [63:0] exp_data[$];
  logic        exp_last[$];
  int          total_words;
  int          op_idx;
  int          res_idx;
  int          rows_done;
  logic        running;
  logic        gnt_en;

  vmul_unit DUT (.*);

  always #5 clk_i = ~clk_i;

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("*** FAILED ***");
    $fatal(1, "run aborted");
  endtask

  // Table columns are op, vsew, vl, vd, vm, scalar flag, scalar value and operand seed
  task automatic load_table();
    rows[0]  = '{VMUL,   EW8,  7'd16, 5'd1,  1'b1, 1'b0, 64'h0, 32'h0000_0011};
    rows[1]  = '{VMUL,   EW16, 7'd8,  5'd2,  1'b1, 1'b0, 64'h0, 32'h0000_2200};
    rows[2]  = '{VMUL,   EW32, 7'd4,  5'd3,  1'b1, 1'b0, 64'h0, 32'h0033_0000};
    rows[3]  = '{VMUL,   EW64, 7'd2,  5'd4,  1'b1, 1'b0, 64'h0, 32'h4400_0000};
    rows[4]  = '{VMULHU, EW8,  7'd13, 5'd5,  1'b0, 1'b0, 64'h0, 32'h5a5a_5a5a};
    rows[5]  = '{VMULHU, EW32, 7'd5,  5'd6,  1'b1, 1'b0, 64'h0, 32'hffff_0000};
    rows[6]  = '{VMACC,  EW16, 7'd10, 5'd7,  1'b0, 1'b0, 64'h0, 32'h0f0f_0f0f};
    rows[7]  = '{VMACC,  EW64, 7'd3,  5'd8,  1'b1, 1'b0, 64'h0, 32'h8000_0001};
    rows[8]  = '{VMUL,   EW8,  7'd11, 5'd9,  1'b1, 1'b1, 64'h0000_0000_0000_00a5, 32'h0};
    rows[9]  = '{VMULHU, EW16, 7'd7,  5'd10, 1'b0, 1'b1, 64'h1234_5678_9abc_def0, 32'h0};
    rows[10] = '{VMACC,  EW32, 7'd3,  5'd11, 1'b1, 1'b1, 64'hdead_beef_8765_4321, 32'h0};
    rows[11] = '{VMUL,   EW64, 7'd1,  5'd12, 1'b0, 1'b1, 64'hffff_ffff_ffff_fffb, 32'h0};
    rows[12] = '{VMUL,   EW8,  7'd64, 5'd31, 1'b1, 1'b0, 64'h0, 32'h1357_9bdf};
  endtask

  function automatic logic [63:0] lane_ref(input vmul_op_e op, input int w, input logic [63:0] a,
                                           input logic [63:0] b, input logic [63:0] c,
                                           input logic [63:0] m);
    logic [127:0] p;
    p = {64'd0, a} * {64'd0, b};
    case (op)
      VMULHU:  return 64'(p >> w) & m;
      VMACC:   return (c + p[63:0]) & m;
      default: return p[63:0] & m;
    endcase
  endfunction

  // Reference result word built lane by lane
  function automatic logic [63:0] expected_word(input row_t rw, input logic [63:0] vs1,
                                                input logic [63:0] vs2, input logic [63:0] vd);
    int          w;
    logic [63:0] m;
    logic [63:0] a;
    logic [63:0] res;
    w   = 8 << int'(rw.vsew);
    m   = {64{1'b1}} >> (64 - w);
    res = '0;
    for (int i = 0; i < 64 / w; i++) begin
      a   = rw.sc ? (rw.scalar & m) : ((vs1 >> (i * w)) & m);
      res = res | (lane_ref(rw.op, w, a, (vs2 >> (i * w)) & m, (vd >> (i * w)) & m, m)
                   << (i * w));
    end
    return res;
  endfunction

  function automatic logic [63:0] byte_bits(input logic [7:0] be);
    logic [63:0] bm;
    for (int j = 0; j < 8; j++) begin
      bm[j*8 +: 8] = {8{be[j]}};
    end
    return bm;
  endfunction

  function automatic vinsn_t make_insn(input int r);
    vinsn_t v;
    v               = '0;
    v.id            = 2'(r % 4);
    v.op            = rows[r].op;
    v.vsew          = rows[r].vsew;
    v.vl            = rows[r].vl;
    v.vd            = rows[r].vd;
    v.scalar_op     = rows[r].scalar;
    v.use_scalar_op = rows[r].sc;
    v.use_vs1       = !rows[r].sc;
    v.use_vs2       = 1'b1;
    v.use_vd        = (rows[r].op == VMACC);
    v.vm            = rows[r].vm;
    return v;
  endfunction

  // One entry per result word holds its operands and expected values
  task automatic build_stream();
    row_t        rw;
    int          pw;
    int          n;
    int          k;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [7:0]  mk;
    logic [7:0]  be;
    for (int r = 0; r < NROWS; r++) begin
      rw = rows[r];
      pw = 8 >> int'(rw.vsew);
      k  = 0;
      for (int e = 0; e < int'(rw.vl); e += pw) begin
        a  = {$urandom, $urandom} ^ {2{rw.seed}};
        b  = {$urandom, $urandom} ^ {2{rw.seed}};
        c  = {$urandom, $urandom} ^ {2{rw.seed}};
        mk = 8'($urandom);
        n  = (int'(rw.vl) - e < pw) ? int'(rw.vl) - e : pw;
        be = 8'hff >> (8 - n * (8 / pw));
        if (!rw.vm) begin
          be = be & mk;
        end
        vs1_q.push_back(a);
        vs2_q.push_back(b);
        vd_q.push_back(c);
        mask_q.push_back(mk);
        row_of.push_back(r);
        exp_id.push_back(2'(r % 4));
        exp_addr.push_back(8'(int'(rw.vd) * `VMUL_VREG_WORDS + k));
        exp_be.push_back(be);
        exp_data.push_back(expected_word(rw, a, b, c));
        exp_last.push_back(e + pw >= int'(rw.vl));
        k++;
      end
    end
    total_words = vs1_q.size();
  endtask

  // Called just after a rising edge and returns just after the accepting edge
  task automatic send_insn(input int r);
    vinsn_i       = make_insn(r);
    vinsn_valid_i = 1'b1;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    vinsn_valid_i = 1'b0;
  endtask

  // Operand bubbles and grant stalls
  always @(posedge clk_i) begin
    if (running) begin
      #1;
      if (op_idx < total_words) begin
        operand_i[0]       = vs1_q[op_idx];
        operand_i[1]       = vs2_q[op_idx];
        operand_i[2]       = vd_q[op_idx];
        mask_i             = mask_q[op_idx];
        operand_valid_i[0] = ($urandom % 4) != 0;
        operand_valid_i[1] = ($urandom % 4) != 0;
        operand_valid_i[2] = ($urandom % 4) != 0;
        mask_valid_i       = ($urandom % 4) != 0;
      end else begin
        operand_valid_i = '0;
        mask_valid_i    = 1'b0;
      end
      result_gnt_i = gnt_en && (($urandom % 3) != 0);
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : monitor
    row_t        rw;
    logic [3:0]  done_exp;
    logic [63:0] bm;
    if (running) begin
      if (operand_ready_o[1]) begin
        if (op_idx >= total_words) begin
          abort_run("operands acknowledged with none pending");
        end
        rw = rows[row_of[op_idx]];
        compare("operand_ready_o", 64'(operand_ready_o), {rw.op == VMACC, 1'b1, !rw.sc});
        compare("mask_ready_o", 64'(mask_ready_o), 64'(!rw.vm));
        op_idx++;
      end else begin
        compare("operand_ready_o", 64'(operand_ready_o), 64'd0);
        compare("mask_ready_o", 64'(mask_ready_o), 64'd0);
      end
      done_exp = '0;
      if (result_req_o && result_gnt_i) begin
        if (res_idx >= total_words) begin
          abort_run("result granted beyond the last expected word");
        end
        bm = byte_bits(exp_be[res_idx]);
        compare("result_id_o", 64'(result_id_o), 64'(exp_id[res_idx]));
        compare("result_addr_o", 64'(result_addr_o), 64'(exp_addr[res_idx]));
        compare("result_be_o", 64'(result_be_o), 64'(exp_be[res_idx]));
        compare("result_wdata_o", result_wdata_o & bm, exp_data[res_idx] & bm);
        if (exp_last[res_idx]) begin
          done_exp = 4'b0001 << exp_id[res_idx];
          rows_done++;
        end
        res_idx++;
      end
      compare("vinsn_done_o", 64'(vinsn_done_o), 64'(done_exp));
    end
  end

  initial begin : watchdog
    repeat (NROWS * 200) @(posedge clk_i);
    abort_run("timeout before all instructions completed");
  end

  initial begin : main
    void'($urandom(SEED));
    rst_ni          = 1'b0;
    vinsn_i         = '0;
    vinsn_valid_i   = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    mask_i          = '0;
    mask_valid_i    = 1'b0;
    result_gnt_i    = 1'b0;
    running         = 1'b0;
    gnt_en          = 1'b0;
    op_idx          = 0;
    res_idx         = 0;
    rows_done       = 0;
    load_table();
    build_stream();

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    compare("ready_o", 64'(ready_o), 64'd1);
    compare("result_req_o", 64'(result_req_o), 64'd0);
    compare("operand_ready_o", 64'(operand_ready_o), 64'd0);
    compare("mask_ready_o", 64'(mask_ready_o), 64'd0);
    compare("vinsn_done_o", 64'(vinsn_done_o), 64'd0);
    @(posedge clk_i);
    #1;
    running = 1'b1;

    for (int r = 0; r < NROWS; r++) begin
      // First four rows fill the queue while grants are withheld
      if (r == 4) begin
        @(negedge clk_i);
        compare("ready_o", 64'(ready_o), 64'd0);
        gnt_en = 1'b1;
        @(posedge clk_i);
        #1;
      end
      send_insn(r);
    end

    wait (rows_done == NROWS);
    repeat (5) @(negedge clk_i);
    if (res_idx == total_words && op_idx == total_words) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      abort_run("result or operand count differs from the expected word count");
    end
  end

endmodule

`default_nettype wire
